/* include/maze_ctl_defines.svh */
`ifndef MAZE_CTL_DEFINES_SVH
`define MAZE_CTL_DEFINES_SVH

// array geometry
`define NRBITS   5   // row coordinate width
`define NCBITS   5   // column coordinate width
`define NLBITS   2   // layer index width
`define NLAYERS  4   // layers stacked in the array

// host words
`define CMD_W    32  // command and result queue word

// per-cell state
`define STATUS_W 4   // cell status code width

`endif

/* maze_ctl.f */
+incdir+include
verilog/maze_cmd_pkg.sv
verilog/maze_cell_pkg.sv
verilog/cmd_latch.sv
verilog/layer_scan.sv
verilog/ctl_fsm.sv
verilog/maze_ctl_top.sv
verif/maze_ctl_chk.sv
verif/maze_ctl_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the maze controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
   echo "verilator is not installed"
   exit 1
fi

verilator --binary --assert --top-module maze_ctl_tb -f maze_ctl.f -Mdir obj_dir -o maze_ctl_sim
if [ $? -ne 0 ]; then
   echo "compile failed"
   exit 1
fi

out=$(./obj_dir/maze_ctl_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "Finished with no errors"; then
   exit 0
fi
exit 1

/* verif/maze_ctl_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module maze_ctl_chk
   import maze_cell_pkg::*;
(
   input wire logic         clk,
   input wire logic         fourlayer_cnt_reset,
   input wire logic         cmd_rd,
   input wire logic         result_wr,
   input wire logic         result_full,
   input wire array_drive_t drive
);

   // --------------------------------------------------
   // queue strobes
   // --------------------------------------------------
   a_no_wr_full: assert property (
      @(posedge clk) disable iff (fourlayer_cnt_reset)
         !(result_wr && result_full))              // full queue takes nothing
   else $error("result_wr high while the result queue is full");

   a_rd_pulse: assert property (
      @(posedge clk) disable iff (fourlayer_cnt_reset)
         cmd_rd |=> !cmd_rd)                       // one word per request
   else $error("cmd_rd held for more than one cycle");

   // cell commands only go out with both decoders active
   a_drive_sel: assert property (
      @(posedge clk) disable iff (fourlayer_cnt_reset)
         (drive.cell_cmd == CC_WRITE || drive.cell_cmd == CC_CLEARX)
         |-> (drive.row_sel != RS_DISABLE && drive.col_sel != RS_DISABLE))
   else $error("write or clearx issued with a decoder disabled");

endmodule

`default_nettype wire

/* verif/maze_ctl_golden.txt */
// columns: command word, status_rd driven while it runs, expected result word
// a result of 00000000 means the command returns nothing, ffffffff ends the list
8670d323 0 00000000  // select p1=(3,7,1) p2=(20,25,3)
c0000009 0 00000000  // write status 9 on layers 1..3
c4000000 5 e0000005  // read p1 on layer 1
cc000000 0 00000000  // clearx, one pass over all layers
c8000000 0 00000000  // clear array
00000000 0 00000000  // nop
dc000000 0 00000000  // unknown function
40000000 0 00000000  // route, taken as nop
82217a22 0 00000000  // select p1=(1,2,2) p2=(30,17,2)
c0000003 0 00000000  // write status 3 on layer 2 only
c4000000 a e000000a  // read p1 on layer 2
81f07c03 0 00000000  // select p1=(0,31,0) p2=(31,0,3)
c000000f 0 00000000  // write status f on all layers
c4000000 7 e0000007  // read p1 on layer 0
ffffffff 0 00000000  // end of list

/* verif/maze_ctl_tb.sv */
`timescale 1ns/1ps
`include "maze_ctl_defines.svh"
`default_nettype none

module maze_ctl_tb
   import maze_cmd_pkg::*;
   import maze_cell_pkg::*;
();

   localparam int          GOLD_WORDS = 96;            // three words per command
   localparam int          WAIT_LIMIT = 200;           // cycles allowed per command
   localparam logic [31:0] END_MARK   = 32'hffff_ffff;

   logic               clk;
   logic               fourlayer_cnt_reset;
   logic               cmd_empty;
   logic [`CMD_W-1:0]  cmd_in;
   logic               cmd_rd;
   logic               result_full;
   result_word_t       result_out;
   logic               result_wr;
   cell_status_t       status_rd;
   array_drive_t       drive;
   logic [`NRBITS-1:0] row_l_v;
   logic [`NRBITS-1:0] row_u_v;
   logic [`NCBITS-1:0] col_l_v;
   logic [`NCBITS-1:0] col_u_v;
   logic [`NLBITS-1:0] cur_layer;

   logic [31:0] golden [0:GOLD_WORDS-1];  // cmd, status_rd, expected result
   logic [31:0] lfsr;
   int          z1_m;         // layer span of the selected box
   int          z2_m;
   logic [31:0] cur_word;     // command being executed
   logic [31:0] cur_result;
   int          n_write;      // range writes seen
   int          n_clear;      // whole-array writes seen
   int          n_clearx;
   int          n_runs;       // separate bursts of clearx
   int          n_result;
   logic        last_clearx;
   int          n_cmds;
   int          i;

   maze_ctl_top dut (
      .clk                 (clk),
      .fourlayer_cnt_reset (fourlayer_cnt_reset),
      .cmd_empty           (cmd_empty),
      .cmd_in              (cmd_in),
      .cmd_rd              (cmd_rd),
      .result_full         (result_full),
      .result_out          (result_out),
      .result_wr           (result_wr),
      .status_rd           (status_rd),
      .drive               (drive),
      .row_l_v             (row_l_v),
      .row_u_v             (row_u_v),
      .col_l_v             (col_l_v),
      .col_u_v             (col_u_v),
      .cur_layer           (cur_layer)
   );

   bind maze_ctl_top maze_ctl_chk u_chk (
      .clk                 (clk),
      .fourlayer_cnt_reset (fourlayer_cnt_reset),
      .cmd_rd              (cmd_rd),
      .result_wr           (result_wr),
      .result_full         (result_full),
      .drive               (drive)
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;   // 8 ns period
   end

   // --------------------------------------------------
   // helpers
   // --------------------------------------------------
   function automatic logic lfsr_bit();
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);  // taps 32,22,2,1
      return lfsr[0];
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("[ERROR] %0t ns %s: got %0h, expected %0h", $time, name, got, exp);
         $display("Finished with errors");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("Finished with errors");
      $fatal(1, "run stopped");
   endtask

   task automatic clear_counts();
      n_write     = 0;
      n_clear     = 0;
      n_clearx    = 0;
      n_runs      = 0;
      n_result    = 0;
      last_clearx = 1'b0;
   endtask

   // one negedge sample of everything the array and result queue see
   task automatic observe_cycle();
      logic is_clearx;
      is_clearx = (drive.cell_cmd == CC_CLEARX);
      if (drive.cell_cmd == CC_WRITE && drive.row_sel == RS_RANGE)
      begin
         n_write++;
         check_value("drive.col_sel", 32'(drive.col_sel), 32'(RS_RANGE));
         check_value("drive.status_wr", 32'(drive.status_wr), 32'(cur_word[3:0]));
         check_value("cur_layer", 32'(cur_layer), 32'((z1_m + n_write - 1) % `NLAYERS));
      end
      if (drive.cell_cmd == CC_WRITE && drive.row_sel == RS_ALL)
      begin
         n_clear++;                                  // layers 0 up to top
         check_value("drive.col_sel", 32'(drive.col_sel), 32'(RS_ALL));
         check_value("drive.status_wr", 32'(drive.status_wr), 32'(CELL_EMPTY_UNETCHED));
         check_value("cur_layer", 32'(cur_layer), 32'(n_clear - 1));
      end
      if (is_clearx)
      begin
         if (!last_clearx)
         begin
            n_runs++;
         end
         n_clearx++;
      end
      last_clearx = is_clearx;
      if (result_wr)
      begin
         n_result++;
         check_value("result_full", 32'(result_full), 32'h0);
         check_value("result_out", 32'(result_out), cur_result);
         check_value("cur_layer", 32'(cur_layer), 32'(z1_m));   // read sits on z1
      end
   endtask

   // run the current command until the FSM asks for the next word
   task automatic run_to_fetch();
      int   waited;
      logic seen_rd;
      waited  = 0;
      seen_rd = 1'b0;
      while (!seen_rd)
      begin
         @(posedge clk);
         result_full <= lfsr_bit() & lfsr_bit();   // full about a quarter of the time
         @(negedge clk);
         observe_cycle();
         seen_rd = cmd_rd;
         waited++;
         if (waited > WAIT_LIMIT)
         begin
            stop_run("timeout: the controller never asked for the next command");
         end
      end
   endtask

   // expected activity follows from the opcode and function of the word
   task automatic check_command();
      logic [1:0] op;
      logic [3:0] fcn;
      int         exp_write;
      int         exp_clear;
      int         exp_clearx;
      int         exp_runs;
      int         exp_result;
      op         = cur_word[31:30];
      fcn        = cur_word[29:26];
      exp_write  = 0;
      exp_clear  = 0;
      exp_clearx = 0;
      exp_runs   = 0;
      exp_result = 0;
      if (op == OP_SELECT)
      begin
         check_value("row_l_v", 32'(row_l_v), 32'(cur_word[24:20]));
         check_value("col_l_v", 32'(col_l_v), 32'(cur_word[29:25]));
         check_value("row_u_v", 32'(row_u_v), 32'(cur_word[9:5]));
         check_value("col_u_v", 32'(col_u_v), 32'(cur_word[14:10]));
         z1_m = int'(cur_word[15 +: `NLBITS]);   // only the low layer bits count
         z2_m = int'(cur_word[0 +: `NLBITS]);
      end
      else if (op == OP_EXTENDED)
      begin
         case (fcn)
            FCN_WRITE:       exp_write  = z2_m - z1_m + 1;
            FCN_READ:        exp_result = 1;
            FCN_CLEAR_ARRAY: exp_clear  = `NLAYERS;
            FCN_CLEARX:
            begin
               exp_clearx = `NLAYERS;
               exp_runs   = 1;                   // one unbroken burst
            end
            default:         exp_write  = 0;     // unknown, nothing happens
         endcase
      end
      check_value("write cycles", 32'(n_write), 32'(exp_write));
      check_value("clear-array writes", 32'(n_clear), 32'(exp_clear));
      check_value("clearx cycles", 32'(n_clearx), 32'(exp_clearx));
      check_value("clearx bursts", 32'(n_runs), 32'(exp_runs));
      check_value("result words", 32'(n_result), 32'(exp_result));
   endtask

   // --------------------------------------------------
   // stimulus
   // --------------------------------------------------
   initial
   begin
      lfsr                = 32'hd86e_557e;
      fourlayer_cnt_reset = 1'b1;
      cmd_empty           = 1'b1;
      cmd_in              = '0;
      result_full         = 1'b0;
      status_rd           = '0;
      z1_m                = 0;   // corners reset to zero
      z2_m                = 0;
      cur_word            = '0;
      cur_result          = '0;
      clear_counts();

      $readmemh("verif/maze_ctl_golden.txt", golden);
      n_cmds = 0;
      while (n_cmds < GOLD_WORDS / 3 && golden[3 * n_cmds] !== END_MARK)
      begin
         n_cmds++;
      end
      if (n_cmds == 0 || n_cmds == GOLD_WORDS / 3)
      begin
         stop_run("golden file is missing, empty or has no end marker");
      end

      repeat (2) @(posedge clk);
      fourlayer_cnt_reset <= 1'b0;
      @(negedge clk);
      check_value("cmd_rd", 32'(cmd_rd), 32'h0);
      check_value("result_wr", 32'(result_wr), 32'h0);
      check_value("drive", 32'(drive), 32'h0);   // read, both decoders off
      check_value("row_l_v", 32'(row_l_v), 32'h0);
      check_value("col_l_v", 32'(col_l_v), 32'h0);
      check_value("row_u_v", 32'(row_u_v), 32'h0);
      check_value("col_u_v", 32'(col_u_v), 32'h0);
      check_value("cur_layer", 32'(cur_layer), 32'h0);

      @(posedge clk);
      cmd_empty <= 1'b0;
      for (i = 0; i < n_cmds; i++)
      begin
         run_to_fetch();
         check_command();                  // previous command is complete
         @(posedge clk);
         cmd_in     <= golden[3 * i];      // queue shows the word after cmd_rd
         status_rd  <= golden[3 * i + 1][`STATUS_W-1:0];
         cur_word   = golden[3 * i];
         cur_result = golden[3 * i + 2];
         clear_counts();
      end
      run_to_fetch();
      check_command();

      // queue runs dry, the slot already fetched reads as a nop
      @(posedge clk);
      cmd_in    <= '0;
      cmd_empty <= 1'b1;
      cur_word  = '0;
      clear_counts();
      repeat (8)
      begin
         @(negedge clk);
         observe_cycle();
         check_value("cmd_rd", 32'(cmd_rd), 32'h0);   // nothing to fetch
      end
      check_command();

      $display("Finished with no errors");
      $finish;
   end

endmodule

`default_nettype wire

/* verilog/cmd_latch.sv */
`timescale 1ns/1ps
`include "maze_ctl_defines.svh"
`default_nettype none

module cmd_latch
   import maze_cmd_pkg::*;
(
   input  wire logic              clk,
   input  wire logic              fourlayer_cnt_reset,
   input  wire logic              load_cmd,     // word from queue is valid now
   input  wire logic              load_points,  // take corners from held select
   input  wire logic [`CMD_W-1:0] cmd_in,
   output cmd_word_t              cmd,
   output point_t                 p1,
   output point_t                 p2
);

   // --------------------------------------------------
   // command register
   // --------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (load_cmd)
      begin
         cmd <= cmd_word_t'(cmd_in);
      end
   end

   // --------------------------------------------------
   // corner registers, plain loads
   // --------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (fourlayer_cnt_reset)
      begin
         p1 <= '0;
         p2 <= '0;
      end
      else if (load_points)
      begin
         // fields are 5 bits wide, keep only what the array uses
         p1.x <= cmd.body.sel.x1[`NCBITS-1:0];
         p1.y <= cmd.body.sel.y1[`NRBITS-1:0];
         p1.z <= cmd.body.sel.z1[`NLBITS-1:0];
         p2.x <= cmd.body.sel.x2[`NCBITS-1:0];
         p2.y <= cmd.body.sel.y2[`NRBITS-1:0];
         p2.z <= cmd.body.sel.z2[`NLBITS-1:0];
      end
   end

endmodule

`default_nettype wire

/* verilog/ctl_fsm.sv */
`timescale 1ns/1ps
`include "maze_ctl_defines.svh"
`default_nettype none

module ctl_fsm
   import maze_cmd_pkg::*;
   import maze_cell_pkg::*;
(
   input  wire logic         clk,
   input  wire logic         fourlayer_cnt_reset,
   input  wire logic         cmd_empty,
   input  wire logic         result_full,
   input  wire cmd_word_t    cmd,
   input  wire cell_status_t status_rd,
   input  wire logic         at_top,
   input  wire logic         at_z1,
   input  wire logic         at_z2,
   input  wire logic         sweep_done,
   output logic              cmd_rd,
   output logic              load_cmd,
   output logic              load_points,
   output logic              advance,
   output logic              sweep_load,
   output array_drive_t      drive,
   output logic              result_wr,
   output result_word_t      result_out
);

   typedef enum logic [3:0] {
      S_WAIT, S_LOAD, S_DECODE, S_SELECT,
      S_WRITE, S_WRITE2, S_READ, S_READ2,
      S_CLEARX, S_CLEARX2, S_CLEARALL, S_CLEARALL2
   } state_e;

   state_e cs;
   state_e ns;

   always_ff @(posedge clk)
   begin
      if (fourlayer_cnt_reset)
      begin
         cs <= S_WAIT;
      end
      else
      begin
         cs <= ns;
      end
   end

   // --------------------------------------------------
   // next state and outputs
   // --------------------------------------------------
   always_comb
   begin
      ns          = S_WAIT;
      cmd_rd      = 1'b0;
      load_cmd    = 1'b0;
      load_points = 1'b0;
      advance     = 1'b0;
      sweep_load  = 1'b0;
      result_wr   = 1'b0;
      result_out  = '0;
      drive.row_sel   = RS_DISABLE;   // read with decoders off is a no-op
      drive.col_sel   = RS_DISABLE;
      drive.cell_cmd  = CC_READ;
      drive.status_wr = CELL_EMPTY_UNETCHED;

      case (cs)
         S_WAIT:
         begin
            if (!cmd_empty)
            begin
               cmd_rd = 1'b1;         // word shows up after this edge
               ns     = S_LOAD;
            end
         end
         S_LOAD:
         begin
            load_cmd = 1'b1;
            ns       = S_DECODE;
         end
         S_DECODE:
         begin
            case (cmd.opcode)
               OP_SELECT:   ns = S_SELECT;
               OP_EXTENDED:
               begin
                  case (cmd.body.ext.fcn)
                     FCN_WRITE:
                     begin
                        drive.row_sel = RS_RANGE;   // prime the decoders
                        drive.col_sel = RS_RANGE;
                        ns = S_WRITE;
                     end
                     FCN_READ:
                     begin
                        drive.row_sel = RS_LOWER;
                        drive.col_sel = RS_LOWER;
                        ns = S_READ;
                     end
                     FCN_CLEAR_ARRAY: ns = S_CLEARALL;
                     FCN_CLEARX:      ns = S_CLEARX;
                     default:         ns = S_WAIT;   // unknown function
                  endcase
               end
               default:                // nop and route
               begin
                  if (!cmd_empty)
                  begin
                     cmd_rd = 1'b1;   // fetch next word right away
                     ns     = S_LOAD;
                  end
               end
            endcase
         end
         S_SELECT:
         begin
            load_points = 1'b1;
            ns          = S_WAIT;
         end
         S_WRITE, S_WRITE2:
         begin
            advance         = 1'b1;
            drive.row_sel   = RS_RANGE;
            drive.col_sel   = RS_RANGE;
            drive.status_wr = cmd.body.ext.status;
            if (cs == S_WRITE2 || at_z1)
            begin
               drive.cell_cmd = CC_WRITE;   // one layer per cycle
               ns = at_z2 ? S_WAIT : S_WRITE2;
            end
            else
            begin
               ns = S_WRITE;                // spin to z1
            end
         end
         S_READ:
         begin
            drive.row_sel = RS_LOWER;
            drive.col_sel = RS_LOWER;
            if (!at_z1)
            begin
               advance = 1'b1;
               ns      = S_READ;
            end
            else
            begin
               ns = result_full ? S_READ : S_READ2;  // hold layer while full
            end
         end
         S_READ2:
         begin
            drive.row_sel     = RS_LOWER;
            drive.col_sel     = RS_LOWER;
            result_out.tag    = RES_STATUS;
            result_out.status = status_rd;
            result_wr         = !result_full;
            ns = result_full ? S_READ2 : S_WAIT;
         end
         S_CLEARX:
         begin
            sweep_load = 1'b1;
            ns         = S_CLEARX2;
         end
         S_CLEARX2:
         begin
            advance        = 1'b1;
            drive.row_sel  = RS_ALL;
            drive.col_sel  = RS_ALL;
            drive.cell_cmd = CC_CLEARX;
            ns = sweep_done ? S_WAIT : S_CLEARX2;
         end
         S_CLEARALL:
         begin
            advance       = 1'b1;
            drive.row_sel = RS_ALL;
            drive.col_sel = RS_ALL;
            ns = at_top ? S_CLEARALL2 : S_CLEARALL;  // start over at layer 0
         end
         S_CLEARALL2:
         begin
            advance         = 1'b1;
            drive.row_sel   = RS_ALL;
            drive.col_sel   = RS_ALL;
            drive.cell_cmd  = CC_WRITE;
            drive.status_wr = CELL_EMPTY_UNETCHED;
            ns = at_top ? S_WAIT : S_CLEARALL2;     // last write on top layer
         end
         default: ns = S_WAIT;
      endcase
   end

endmodule

`default_nettype wire

/* verilog/layer_scan.sv */
`timescale 1ns/1ps
`include "maze_ctl_defines.svh"
`default_nettype none

module layer_scan
(
   input  wire logic               clk,
   input  wire logic               fourlayer_cnt_reset,
   input  wire logic               advance,     // step to next layer
   input  wire logic               sweep_load,  // start a full pass
   input  wire logic [`NLBITS-1:0] p1_z,
   input  wire logic [`NLBITS-1:0] p2_z,
   output logic      [`NLBITS-1:0] cur_layer,
   output logic                    at_top,
   output logic                    at_z1,
   output logic                    at_z2,
   output logic                    sweep_done
);

   localparam logic [`NLBITS-1:0] TOP_LAYER = `NLBITS'(`NLAYERS - 1);

   logic [`NLBITS-1:0] sweep_count;  // layers left in the pass

   // --------------------------------------------------
   // rotating layer pointer
   // --------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (fourlayer_cnt_reset)
      begin
         cur_layer <= '0;
      end
      else if (advance)
      begin
         cur_layer <= at_top ? '0 : cur_layer + 1'b1;  // wrap after top
      end
   end

   // pass timer, load wins over step
   always_ff @(posedge clk)
   begin
      if (fourlayer_cnt_reset)
      begin
         sweep_count <= '0;
      end
      else if (sweep_load)
      begin
         sweep_count <= TOP_LAYER;
      end
      else if (advance)
      begin
         sweep_count <= sweep_count - 1'b1;
      end
   end

   assign at_top     = (cur_layer == TOP_LAYER);
   assign at_z1      = (cur_layer == p1_z);       // on p1 layer
   assign at_z2      = (cur_layer == p2_z);       // on p2 layer
   assign sweep_done = (sweep_count == '0);

endmodule

`default_nettype wire

/* verilog/maze_cell_pkg.sv */
`include "maze_ctl_defines.svh"
`default_nettype none

package maze_cell_pkg;

   typedef logic [`STATUS_W-1:0] cell_status_t;

   // bit 3 marks an etched cell
   localparam cell_status_t CELL_TRACED         = 4'b1001;
   localparam cell_status_t CELL_EMPTY_UNETCHED = 4'b0000;  // value after clear

   // per-cell command bus
   typedef enum logic [1:0] {
      CC_READ   = 2'd0,   // no-op when nothing is selected
      CC_WRITE  = 2'd1,
      CC_EXPAND = 2'd2,   // wavefront step, not issued here
      CC_CLEARX = 2'd3    // drop expanded marks, keep obstacles
   } cell_cmd_e;

   // row / column range decoder mode
   typedef enum logic [2:0] {
      RS_DISABLE = 3'd0,
      RS_LOWER   = 3'd1,   // single line at lower value
      RS_UPPER   = 3'd2,   // single line at upper value
      RS_RANGE   = 3'd3,   // lower through upper
      RS_ALL     = 3'd4
   } range_sel_e;

   // everything the array sees from the controller
   typedef struct packed {
      range_sel_e   row_sel;
      range_sel_e   col_sel;
      cell_cmd_e    cell_cmd;
      cell_status_t status_wr;
   } array_drive_t;

endpackage

`default_nettype wire

/* verilog/maze_cmd_pkg.sv */
`include "maze_ctl_defines.svh"
`default_nettype none

package maze_cmd_pkg;

   typedef enum logic [1:0] {
      OP_NOP      = 2'd0,
      OP_ROUTE    = 2'd1,   // not supported, decoded as nop
      OP_SELECT   = 2'd2,
      OP_EXTENDED = 2'd3
   } cmd_opcode_e;

   typedef enum logic [3:0] {
      FCN_WRITE       = 4'd0,
      FCN_READ        = 4'd1,
      FCN_CLEAR_ARRAY = 4'd2,
      FCN_CLEARX      = 4'd3
   } cmd_fcn_e;

   // extended opcode layout, bits 29:0
   typedef struct packed {
      cmd_fcn_e                fcn;     // 29:26
      logic [21:0]             unused;  // 25:4
      logic [`STATUS_W-1:0]    status;  // 3:0, value for write
   } ext_fields_t;

   // select layout, bits 29:0, 5 bits per coordinate
   typedef struct packed {
      logic [4:0] x1;
      logic [4:0] y1;
      logic [4:0] z1;
      logic [4:0] x2;
      logic [4:0] y2;
      logic [4:0] z2;
   } sel_fields_t;

   typedef union packed {
      ext_fields_t ext;
      sel_fields_t sel;
   } cmd_body_t;

   typedef struct packed {
      cmd_opcode_e opcode;   // 31:30
      cmd_body_t   body;
   } cmd_word_t;

   // corner point, sized to the array
   typedef struct packed {
      logic [`NCBITS-1:0] x;
      logic [`NRBITS-1:0] y;
      logic [`NLBITS-1:0] z;
   } point_t;

   typedef enum logic [2:0] {
      RES_ETCH    = 3'd0,
      RES_SUCCESS = 3'd1,
      RES_XFAIL   = 3'd2,
      RES_TFAIL   = 3'd3,
      RES_TRACE   = 3'd4,
      RES_XCOUNT  = 3'd5,
      RES_TCOUNT  = 3'd6,
      RES_STATUS  = 3'd7
   } result_tag_e;

   typedef struct packed {
      result_tag_e          tag;     // 31:29
      logic [24:0]          pad;     // always zero
      logic [`STATUS_W-1:0] status;  // 3:0
   } result_word_t;

endpackage

`default_nettype wire

/* verilog/maze_ctl_top.sv */
`timescale 1ns/1ps
`include "maze_ctl_defines.svh"
`default_nettype none

module maze_ctl_top
   import maze_cmd_pkg::*;
   import maze_cell_pkg::*;
(
   input  wire logic               clk,
   input  wire logic               fourlayer_cnt_reset,
   // command queue
   input  wire logic               cmd_empty,
   input  wire logic [`CMD_W-1:0]  cmd_in,
   output logic                    cmd_rd,
   // result queue
   input  wire logic               result_full,
   output result_word_t            result_out,
   output logic                    result_wr,
   // cell array
   input  wire cell_status_t       status_rd,
   output array_drive_t            drive,
   output logic [`NRBITS-1:0]      row_l_v,
   output logic [`NRBITS-1:0]      row_u_v,
   output logic [`NCBITS-1:0]      col_l_v,
   output logic [`NCBITS-1:0]      col_u_v,
   output logic [`NLBITS-1:0]      cur_layer
);

   cmd_word_t cmd;
   point_t    p1;
   point_t    p2;
   logic      load_cmd;
   logic      load_points;
   logic      advance;
   logic      sweep_load;
   logic      at_top;
   logic      at_z1;
   logic      at_z2;
   logic      sweep_done;

   // p1 feeds the lower decoder values, p2 the upper
   assign row_l_v = p1.y;
   assign col_l_v = p1.x;
   assign row_u_v = p2.y;
   assign col_u_v = p2.x;

   cmd_latch u_latch (
      .clk                 (clk),
      .fourlayer_cnt_reset (fourlayer_cnt_reset),
      .load_cmd            (load_cmd),
      .load_points         (load_points),
      .cmd_in              (cmd_in),
      .cmd                 (cmd),
      .p1                  (p1),
      .p2                  (p2)
   );

   layer_scan u_scan (
      .clk                 (clk),
      .fourlayer_cnt_reset (fourlayer_cnt_reset),
      .advance             (advance),
      .sweep_load          (sweep_load),
      .p1_z                (p1.z),
      .p2_z                (p2.z),
      .cur_layer           (cur_layer),
      .at_top              (at_top),
      .at_z1               (at_z1),
      .at_z2               (at_z2),
      .sweep_done          (sweep_done)
   );

   ctl_fsm u_fsm (
      .clk                 (clk),
      .fourlayer_cnt_reset (fourlayer_cnt_reset),
      .cmd_empty           (cmd_empty),
      .result_full         (result_full),
      .cmd                 (cmd),
      .status_rd           (status_rd),
      .at_top              (at_top),
      .at_z1               (at_z1),
      .at_z2               (at_z2),
      .sweep_done          (sweep_done),
      .cmd_rd              (cmd_rd),
      .load_cmd            (load_cmd),
      .load_points         (load_points),
      .advance             (advance),
      .sweep_load          (sweep_load),
      .drive               (drive),
      .result_wr           (result_wr),
      .result_out          (result_out)
   );

endmodule

`default_nettype wire
